// File: include/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// width of one instruction word
`define INST_WIDTH 32

// immediates, pc and data path
`define DATA_WIDTH 32

// register index, x0..x31
`define REG_WIDTH 5

`endif

// File: verilog/isa_pkg.sv
package isa_pkg;

	// rv32i major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b01101_11;
	localparam logic [6:0] OPC_AUIPC  = 7'b00101_11;
	localparam logic [6:0] OPC_JAL    = 7'b11011_11;
	localparam logic [6:0] OPC_JALR   = 7'b11001_11;
	localparam logic [6:0] OPC_BRANCH = 7'b11000_11;
	localparam logic [6:0] OPC_LOAD   = 7'b00000_11;
	localparam logic [6:0] OPC_STORE  = 7'b01000_11;
	localparam logic [6:0] OPC_OP_IMM = 7'b00100_11;
	localparam logic [6:0] OPC_OP     = 7'b01100_11;
	localparam logic [6:0] OPC_FENCE  = 7'b00011_11;
	localparam logic [6:0] OPC_SYSTEM = 7'b11100_11;

	// alu operation handed to execute
	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_opt_e;

	// operand pair fed to the alu
	typedef enum logic [1:0] {
		SRC_RS1_IMM = 2'd0,
		SRC_PC_IMM,
		SRC_PC_4,
		SRC_RS1_RS2
	} src_sel_e;

	// memory / system class, sys covers csr access
	typedef enum logic [1:0] {
		LSU_NONE,
		LSU_LOAD,
		LSU_STORE,
		LSU_SYS
	} lsu_opt_e;

endpackage

// File: verilog/pipe_pkg.sv
`include "rv_params.svh"

package pipe_pkg;

	// fetch side packet, class bits come from predecode
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] pc;
		logic [`INST_WIDTH-1:0] inst;
		logic                   jal;
		logic                   jalr;
		logic                   branch;
		logic                   sys;
	} fetch_pkt_t;

	// decoded packet handed to execute
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] pc;
		// unused register fields are zero
		logic [`REG_WIDTH-1:0]  rd;
		logic [`REG_WIDTH-1:0]  rs1;
		logic [`REG_WIDTH-1:0]  rs2;
		logic                   rd_wen;
		// sign extended, csr number and zimm for system
		logic [`DATA_WIDTH-1:0] imm;
		isa_pkg::alu_opt_e      alu_opt;
		isa_pkg::src_sel_e      src_sel;
		isa_pkg::lsu_opt_e      lsu_opt;
		// raw funct3, selects branch compare and load/store size later
		logic [2:0]             funct3;
	} decode_pkt_t;

endpackage

// File: verilog/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  payload_t in_pkt,
	output logic     out_valid,
	output payload_t out_pkt
);

	// no stall, so the valid bit simply follows the strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_pkt   <= '0;
		end else begin
			out_valid <= in_valid;
			// hold the old payload on idle cycles to save toggling
			if (in_valid) begin
				out_pkt <= in_pkt;
			end
		end
	end

endmodule

// File: verilog/predecode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module predecode (
	input  logic [`INST_WIDTH-1:0] inst,
	output logic                   jal,
	output logic                   jalr,
	output logic                   branch,
	output logic                   sys
);

	logic [6:0] opcode;

	// major opcode sits in the low seven bits
	assign opcode = inst[6:0];

	// control flow marks, usable by a next-pc unit before decode
	assign jal    = (opcode == isa_pkg::OPC_JAL);
	assign jalr   = (opcode == isa_pkg::OPC_JALR);
	assign branch = (opcode == isa_pkg::OPC_BRANCH);

	// ecall, ebreak and the csr group
	assign sys    = (opcode == isa_pkg::OPC_SYSTEM);

endmodule

// File: verilog/id_opt.sv
`timescale 1ns/1ps

module id_opt (
	input  logic [6:0]        opcode,
	input  logic [2:0]        funct3,
	// inst[30], picks sub and sra
	input  logic              funct7,
	output isa_pkg::alu_opt_e alu_opt,
	output isa_pkg::src_sel_e src_sel,
	output isa_pkg::lsu_opt_e lsu_opt
);

	// shared funct3 table of op and op_imm
	// sub only exists for register-register
	function automatic isa_pkg::alu_opt_e arith_opt(
		input logic [2:0] f3,
		input logic       f7,
		input logic       is_reg
	);
		isa_pkg::alu_opt_e opt;
		case (f3)
			3'b000:  opt = (is_reg && f7) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
			3'b001:  opt = isa_pkg::ALU_SLL;
			3'b010:  opt = isa_pkg::ALU_SLT;
			3'b011:  opt = isa_pkg::ALU_SLTU;
			3'b100:  opt = isa_pkg::ALU_XOR;
			3'b101:  opt = f7 ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
			3'b110:  opt = isa_pkg::ALU_OR;
			default: opt = isa_pkg::ALU_AND;
		endcase
		return opt;
	endfunction

	always_comb begin
		alu_opt = isa_pkg::ALU_NONE;
		src_sel = isa_pkg::SRC_RS1_IMM;
		lsu_opt = isa_pkg::LSU_NONE;
		case (opcode)
			isa_pkg::OPC_OP_IMM: begin
				alu_opt = arith_opt(funct3, funct7, 1'b0);
			end
			isa_pkg::OPC_OP: begin
				alu_opt = arith_opt(funct3, funct7, 1'b1);
				src_sel = isa_pkg::SRC_RS1_RS2;
			end
			isa_pkg::OPC_BRANCH: begin
				// beq/bne compare by subtraction, the rest by set-less-than
				if (funct3[2:1] == 2'b00) begin
					alu_opt = isa_pkg::ALU_SUB;
				end else if (funct3[2:1] == 2'b10) begin
					alu_opt = isa_pkg::ALU_SLT;
				end else if (funct3[2:1] == 2'b11) begin
					alu_opt = isa_pkg::ALU_SLTU;
				end
				src_sel = isa_pkg::SRC_RS1_RS2;
			end
			isa_pkg::OPC_LUI: begin
				alu_opt = isa_pkg::ALU_ADD;
			end
			isa_pkg::OPC_AUIPC: begin
				alu_opt = isa_pkg::ALU_ADD;
				src_sel = isa_pkg::SRC_PC_IMM;
			end
			isa_pkg::OPC_JAL, isa_pkg::OPC_JALR: begin
				// link value pc + 4 is computed in the alu
				alu_opt = isa_pkg::ALU_ADD;
				src_sel = isa_pkg::SRC_PC_4;
			end
			isa_pkg::OPC_LOAD: begin
				// address = rs1 + imm
				alu_opt = isa_pkg::ALU_ADD;
				lsu_opt = isa_pkg::LSU_LOAD;
			end
			isa_pkg::OPC_STORE: begin
				alu_opt = isa_pkg::ALU_ADD;
				lsu_opt = isa_pkg::LSU_STORE;
			end
			isa_pkg::OPC_SYSTEM: begin
				lsu_opt = isa_pkg::LSU_SYS;
			end
			// fence and unknown opcodes decode as nop
			default: begin
				alu_opt = isa_pkg::ALU_NONE;
			end
		endcase
	end

endmodule

// File: verilog/idu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module idu (
	input  pipe_pkg::fetch_pkt_t  fetch,
	output pipe_pkg::decode_pkt_t dec
);

	logic [`INST_WIDTH-1:0] inst;
	logic [6:0]             opcode;
	logic                   is_lui;
	logic                   is_auipc;
	logic                   is_load;
	logic                   is_store;
	logic                   is_op_imm;
	logic                   is_op;
	logic                   i_type;
	logic                   u_type;
	logic                   b_type;
	logic                   s_type;
	logic                   rs1_used;
	logic                   rs2_used;
	logic                   rd_used;
	logic [`DATA_WIDTH-1:0] imm;

	assign inst   = fetch.inst;
	assign opcode = inst[6:0];

	// jal, jalr, branch and sys were already classified in predecode
	assign is_lui    = (opcode == isa_pkg::OPC_LUI);
	assign is_auipc  = (opcode == isa_pkg::OPC_AUIPC);
	assign is_load   = (opcode == isa_pkg::OPC_LOAD);
	assign is_store  = (opcode == isa_pkg::OPC_STORE);
	assign is_op_imm = (opcode == isa_pkg::OPC_OP_IMM);
	assign is_op     = (opcode == isa_pkg::OPC_OP);

	// instruction formats, j is jal alone and r is op alone
	assign i_type = fetch.jalr | is_load | is_op_imm | fetch.sys;
	assign u_type = is_lui | is_auipc;
	assign b_type = fetch.branch;
	assign s_type = is_store;

	// which register fields are live
	assign rs1_used = i_type | b_type | s_type | is_op;
	assign rs2_used = b_type | s_type | is_op;
	assign rd_used  = u_type | fetch.jal | i_type | is_op;

	// immediate select, zero for op and fence
	always_comb begin
		imm = '0;
		if (fetch.sys) begin
			// csr number plus zimm, sign taken from bit 31
			imm = {{15{inst[31]}}, inst[31:15]};
		end else if (i_type) begin
			imm = {{20{inst[31]}}, inst[31:20]};
		end else if (u_type) begin
			imm = {inst[31:12], 12'd0};
		end else if (fetch.jal) begin
			imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		end else if (b_type) begin
			imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		end else if (s_type) begin
			imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		end
	end

	assign dec.pc     = fetch.pc;
	assign dec.rd     = rd_used  ? inst[11:7]  : '0;
	assign dec.rs1    = rs1_used ? inst[19:15] : '0;
	assign dec.rs2    = rs2_used ? inst[24:20] : '0;
	assign dec.rd_wen = rd_used;
	assign dec.imm    = imm;
	assign dec.funct3 = inst[14:12];

	// alu, operand and lsu control
	id_opt id_opt_i (
		.opcode  (opcode),
		.funct3  (inst[14:12]),
		.funct7  (inst[30]),
		.alu_opt (dec.alu_opt),
		.src_sel (dec.src_sel),
		.lsu_opt (dec.lsu_opt)
	);

endmodule

// File: verilog/decode_stage_top.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module decode_stage_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   in_valid,
	input  logic [`DATA_WIDTH-1:0] in_pc,
	input  logic [`INST_WIDTH-1:0] in_inst,
	output logic                   out_valid,
	output pipe_pkg::decode_pkt_t  out_pkt
);

	pipe_pkg::fetch_pkt_t  fetch_d;
	pipe_pkg::fetch_pkt_t  fetch_q;
	logic                  fetch_valid;
	pipe_pkg::decode_pkt_t dec_d;

	assign fetch_d.pc   = in_pc;
	assign fetch_d.inst = in_inst;

	// class bits land straight in the fetch packet
	predecode predecode_i (
		.inst   (in_inst),
		.jal    (fetch_d.jal),
		.jalr   (fetch_d.jalr),
		.branch (fetch_d.branch),
		.sys    (fetch_d.sys)
	);

	// fetch/decode boundary
	stage_reg #(.payload_t(pipe_pkg::fetch_pkt_t)) fetch_reg_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_pkt    (fetch_d),
		.out_valid (fetch_valid),
		.out_pkt   (fetch_q)
	);

	idu idu_i (
		.fetch (fetch_q),
		.dec   (dec_d)
	);

	// decode/execute boundary, second cycle of latency
	stage_reg #(.payload_t(pipe_pkg::decode_pkt_t)) decode_reg_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (fetch_valid),
		.in_pkt    (dec_d),
		.out_valid (out_valid),
		.out_pkt   (out_pkt)
	);

endmodule

// File: dv/decode_assertions.sv
`timescale 1ns/1ps

module decode_assertions (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  in_valid,
	input logic                  out_valid,
	input pipe_pkg::decode_pkt_t out_pkt
);

	// number of failed assertions, read at the end of the run
	int fail_count = 0;

	// both stage registers clear asynchronously
	reset_valid_a: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else begin
			$error("out_valid high while reset is held");
			fail_count++;
		end

	// fixed two-cycle latency, no stall path
	latency_a: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid, 2))
		else begin
			$error("out_valid does not follow in_valid by two cycles");
			fail_count++;
		end

	// rd field is zeroed when no write happens
	rd_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
		!out_pkt.rd_wen |-> (out_pkt.rd == '0))
		else begin
			$error("rd nonzero while rd_wen is low");
			fail_count++;
		end

endmodule

bind decode_stage_top decode_assertions decode_assertions_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_pkt   (out_pkt)
);

// File: dv/decode_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module decode_tb;

	// clocks per test: instructions plus two drain cycles, reset phases included
	localparam int TOTAL_CYCLES = 18 + 16 + 7 + 5 + 42 + 10 + 5;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 50) * 20;

	logic                   clk;
	logic                   arst_n;
	logic                   in_valid;
	logic [`DATA_WIDTH-1:0] in_pc;
	logic [`INST_WIDTH-1:0] in_inst;
	logic                   out_valid;
	pipe_pkg::decode_pkt_t  out_pkt;

	int                     errors;
	integer                 seed;
	string                  test_name;
	logic [`DATA_WIDTH-1:0] pc_cnt;
	// one entry per driven cycle, oldest first
	logic                   exp_valid_q[$];
	pipe_pkg::decode_pkt_t  exp_pkt_q[$];
	// packet the output register holds over idle cycles
	pipe_pkg::decode_pkt_t  last_pkt;

	decode_stage_top dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_pc     (in_pc),
		.in_inst   (in_inst),
		.out_valid (out_valid),
		.out_pkt   (out_pkt)
	);

	always #10 clk = ~clk;

	// funct3 table of op and op_imm, sub only for register-register
	function automatic isa_pkg::alu_opt_e alu_ref(input logic [2:0] f3, input logic f7,
			input logic is_reg);
		case (f3)
			3'b000:  return (f7 && is_reg) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
			3'b001:  return isa_pkg::ALU_SLL;
			3'b010:  return isa_pkg::ALU_SLT;
			3'b011:  return isa_pkg::ALU_SLTU;
			3'b100:  return isa_pkg::ALU_XOR;
			3'b101:  return f7 ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
			3'b110:  return isa_pkg::ALU_OR;
			default: return isa_pkg::ALU_AND;
		endcase
	endfunction

	// expected packet straight from the rv32i encoding rules
	function automatic pipe_pkg::decode_pkt_t ref_decode(input logic [`DATA_WIDTH-1:0] pc,
			input logic [`INST_WIDTH-1:0] i);
		pipe_pkg::decode_pkt_t d;
		logic                  use_rd;
		logic                  use_rs1;
		logic                  use_rs2;
		d = '0;
		use_rd = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		d.pc = pc;
		d.funct3 = i[14:12];
		case (i[6:0])
			isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC: begin
				use_rd = 1'b1;
				d.imm = {i[31:12], 12'h000};
				d.alu_opt = isa_pkg::ALU_ADD;
				if (i[6:0] == isa_pkg::OPC_AUIPC) begin
					d.src_sel = isa_pkg::SRC_PC_IMM;
				end
			end
			isa_pkg::OPC_JAL: begin
				use_rd = 1'b1;
				d.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
				d.alu_opt = isa_pkg::ALU_ADD;
				d.src_sel = isa_pkg::SRC_PC_4;
			end
			isa_pkg::OPC_JALR, isa_pkg::OPC_LOAD: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				d.imm = {{20{i[31]}}, i[31:20]};
				d.alu_opt = isa_pkg::ALU_ADD;
				if (i[6:0] == isa_pkg::OPC_JALR) begin
					d.src_sel = isa_pkg::SRC_PC_4;
				end else begin
					d.lsu_opt = isa_pkg::LSU_LOAD;
				end
			end
			isa_pkg::OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				d.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
				d.src_sel = isa_pkg::SRC_RS1_RS2;
				if (i[14:13] == 2'b00) begin
					d.alu_opt = isa_pkg::ALU_SUB;
				end else if (i[14:13] == 2'b10) begin
					d.alu_opt = isa_pkg::ALU_SLT;
				end else if (i[14:13] == 2'b11) begin
					d.alu_opt = isa_pkg::ALU_SLTU;
				end
			end
			isa_pkg::OPC_STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				d.imm = {{20{i[31]}}, i[31:25], i[11:7]};
				d.alu_opt = isa_pkg::ALU_ADD;
				d.lsu_opt = isa_pkg::LSU_STORE;
			end
			isa_pkg::OPC_OP_IMM: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				d.imm = {{20{i[31]}}, i[31:20]};
				d.alu_opt = alu_ref(i[14:12], i[30], 1'b0);
			end
			isa_pkg::OPC_OP: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				d.alu_opt = alu_ref(i[14:12], i[30], 1'b1);
				d.src_sel = isa_pkg::SRC_RS1_RS2;
			end
			isa_pkg::OPC_SYSTEM: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				// csr number and zimm side by side
				d.imm = {{15{i[31]}}, i[31:15]};
				d.lsu_opt = isa_pkg::LSU_SYS;
			end
			default: begin
				// fence and unknown opcodes stay all zero
				d.imm = '0;
			end
		endcase
		d.rd_wen = use_rd;
		d.rd = use_rd ? i[11:7] : 5'd0;
		d.rs1 = use_rs1 ? i[19:15] : 5'd0;
		d.rs2 = use_rs2 ? i[24:20] : 5'd0;
		return d;
	endfunction

	// raw field layout, every format is a view of these fields
	function automatic logic [31:0] enc(input logic [6:0] hi, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {hi, rs2, rs1, f3, rd, opc};
	endfunction

	// one clock: check the output of two steps back, then drive on the falling edge
	task automatic step(input logic valid, input logic [31:0] inst);
		logic                  exp_v;
		pipe_pkg::decode_pkt_t exp_p;
		@(negedge clk);
		if (exp_valid_q.size() == 2) begin
			exp_v = exp_valid_q.pop_front();
			exp_p = exp_pkt_q.pop_front();
			assert (out_valid === exp_v) else begin
				$display("[ERROR] %s: out_valid expected %b actual %b", test_name, exp_v,
					out_valid);
				errors++;
			end
			// idle slots keep the last decoded packet
			if (exp_v) begin
				last_pkt = exp_p;
			end
			assert (out_pkt === last_pkt) else begin
				$display("[ERROR] %s: out_pkt expected %h actual %h", test_name, last_pkt,
					out_pkt);
				errors++;
			end
		end
		in_valid = valid;
		in_pc = pc_cnt;
		in_inst = inst;
		exp_valid_q.push_back(valid);
		exp_pkt_q.push_back(ref_decode(pc_cnt, inst));
		pc_cnt = pc_cnt + 32'd4;
	endtask

	// idle cycles until the last instruction has been checked
	task automatic flush();
		step(1'b0, 32'h0);
		step(1'b0, 32'h0);
	endtask

	task automatic test_r_type();
		test_name = "r_type";
		for (int f = 0; f < 16; f++) begin
			step(1'b1, enc({1'b0, f[3], 5'd0}, 5'(f + 1), 5'(f + 9), f[2:0], 5'(f + 17),
				isa_pkg::OPC_OP));
		end
		flush();
	endtask

	task automatic test_immediates();
		logic [6:0] opcs [7] = '{isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC, isa_pkg::OPC_JAL,
			isa_pkg::OPC_JALR, isa_pkg::OPC_LOAD, isa_pkg::OPC_STORE, isa_pkg::OPC_BRANCH};
		test_name = "immediates";
		// bit 31 clear first, then set
		for (int p = 0; p < 2; p++) begin
			for (int k = 0; k < 7; k++) begin
				step(1'b1, enc({p[0], 6'h2d}, 5'h13, 5'h0a, k[2:0], 5'h15, opcs[k]));
			end
		end
		flush();
	endtask

	task automatic test_zeroing();
		test_name = "zeroing";
		step(1'b1, enc(7'h55, 5'h1b, 5'h0d, 3'b010, 5'h07, isa_pkg::OPC_STORE));
		step(1'b1, enc(7'h55, 5'h1b, 5'h0d, 3'b001, 5'h07, isa_pkg::OPC_BRANCH));
		step(1'b1, enc(7'h55, 5'h1b, 5'h0d, 3'b001, 5'h07, isa_pkg::OPC_LUI));
		step(1'b1, enc(7'h55, 5'h1b, 5'h0d, 3'b001, 5'h07, isa_pkg::OPC_JAL));
		step(1'b1, enc(7'h55, 5'h1b, 5'h0d, 3'b001, 5'h07, isa_pkg::OPC_FENCE));
		flush();
	endtask

	task automatic test_system();
		test_name = "system";
		// csrrw mstatus, csrrs on a high csr, csrrci with zimm
		step(1'b1, enc(7'h18, 5'h00, 5'h05, 3'b001, 5'h0a, isa_pkg::OPC_SYSTEM));
		step(1'b1, enc(7'h7c, 5'h01, 5'h1f, 3'b010, 5'h03, isa_pkg::OPC_SYSTEM));
		step(1'b1, enc(7'h34, 5'h04, 5'h11, 3'b111, 5'h1c, isa_pkg::OPC_SYSTEM));
		flush();
	endtask

	task automatic test_pipeline();
		logic [6:0] opcs [11] = '{isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC, isa_pkg::OPC_JAL,
			isa_pkg::OPC_JALR, isa_pkg::OPC_BRANCH, isa_pkg::OPC_LOAD, isa_pkg::OPC_STORE,
			isa_pkg::OPC_OP_IMM, isa_pkg::OPC_OP, isa_pkg::OPC_FENCE, isa_pkg::OPC_SYSTEM};
		logic [31:0] word;
		logic [31:0] sel;
		test_name = "pipeline";
		for (int n = 0; n < 40; n++) begin
			word = $random(seed);
			sel = $random(seed);
			// about three in four cycles carry an instruction
			step(sel[4] | sel[5], {word[31:7], opcs[sel[3:0] % 4'd11]});
		end
		flush();
	endtask

	task automatic test_reset();
		test_name = "reset";
		@(negedge clk);
		arst_n = 1'b0;
		in_valid = 1'b0;
		repeat (5) @(negedge clk);
		assert (out_valid === 1'b0) else begin
			$display("[ERROR] %s: out_valid during reset expected 0 actual %b", test_name,
				out_valid);
			errors++;
		end
		arst_n = 1'b1;
		// reset empties the pipeline and clears both payloads
		exp_valid_q.delete();
		exp_pkt_q.delete();
		last_pkt = '0;
		exp_valid_q.push_back(1'b0);
		exp_pkt_q.push_back('0);
		exp_valid_q.push_back(1'b0);
		exp_pkt_q.push_back('0);
		step(1'b1, enc(7'h7f, 5'h1e, 5'h02, 3'b000, 5'h09, isa_pkg::OPC_OP_IMM));
		flush();
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_inst = '0;
		errors = 0;
		seed = 32'hbf8f;
		pc_cnt = 32'h0000_1000;
		last_pkt = '0;
		test_name = "init";
		// edge on arst_n so the registers clear
		#1 arst_n = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		test_r_type();
		test_immediates();
		test_zeroing();
		test_system();
		test_pipeline();
		test_reset();
		$display("decode_tb finished with %0d check errors and %0d assertion failures",
			errors, dut_i.decode_assertions_i.fail_count);
		if (errors == 0 && dut_i.decode_assertions_i.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/predecode.sv
verilog/id_opt.sv
verilog/idu.sv
verilog/decode_stage_top.sv
dv/decode_assertions.sv
dv/decode_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = decode_tb
FLIST     = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
